// ==== src/stepper_defs.svh ====
`ifndef STEPPER_DEFS_SVH
`define STEPPER_DEFS_SVH

// signed step count per move
// sign bit selects the direction
`define STEP_COUNT_BITS 8

// pulse width in ticks
// applies to both the low and the high phase
`define STEP_WIDTH_BITS 8

// clk cycles per tick strobe
`define STEP_TICK_DIV 4

`endif

// ==== src/stepper_pkg.sv ====
`include "stepper_defs.svh"

package stepper_pkg;

	// command for one axis
	// steps is two's complement, negative means reverse
	// width is the length of each phase in ticks
	typedef struct packed {
		logic signed [`STEP_COUNT_BITS-1:0] steps;
		logic [`STEP_WIDTH_BITS-1:0] width;
	} step_cmd_t;

	// outputs of one axis
	// out is the step pulse to the driver
	// dir is high for a negative count
	// done is high whenever the axis is idle
	typedef struct packed {
		logic out;
		logic dir;
		logic done;
	} axis_status_t;

	// axis sequencer states
	// one low phase then one high phase per step
	typedef enum logic [1:0] {
		idle       = 2'd0,
		phase_low  = 2'd1,
		phase_high = 2'd2
	} stepper_state_e;

endpackage : stepper_pkg

// ==== src/tick_gen.sv ====
`timescale 1ns/10ps
`include "stepper_defs.svh"

module tick_gen (
	input logic clk,
	input logic reset,
	output logic tick
);

	// one extra bit keeps the width legal for a divisor of one
	localparam int CNT_BITS = $clog2(`STEP_TICK_DIV + 1);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`STEP_TICK_DIV - 1);

	logic [CNT_BITS-1:0] cnt;

	// modulo counter of the divisor
	// tick is registered so it is a clean one-cycle strobe
	// first tick comes STEP_TICK_DIV cycles after reset drops
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			tick <= 1'b0;
		end
		else if (cnt == CNT_LAST) begin
			// wrap and fire
			cnt <= '0;
			tick <= 1'b1;
		end
		else begin
			cnt <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule : tick_gen

// ==== src/stepper_fsm.sv ====
`timescale 1ns/10ps

module stepper_fsm (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic trigger,
	input logic phase_end,
	input logic last_step,
	input logic null_move,
	output stepper_pkg::stepper_state_e state,
	output logic clear_width,
	output logic count_step
);

	stepper_pkg::stepper_state_e next_state;

	// state register
	// all movement happens on a tick edge only
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stepper_pkg::idle;
		end
		else begin
			state <= next_state;
		end
	end

	// next state and counter strobes
	// strobes are only raised together with tick
	always_comb begin
		next_state = state;
		clear_width = 1'b0;
		count_step = 1'b0;

		case (state)
			stepper_pkg::idle: begin
				// trigger is a level, sampled on the tick
				// a zero width or zero count never leaves idle
				if (tick && trigger && !null_move) begin
					next_state = stepper_pkg::phase_low;
					clear_width = 1'b1;
				end
			end

			stepper_pkg::phase_low: begin
				// low phase done, start the high half of the step
				if (tick && phase_end) begin
					next_state = stepper_pkg::phase_high;
					clear_width = 1'b1;
				end
			end

			stepper_pkg::phase_high: begin
				// end of one full step
				if (tick && phase_end) begin
					clear_width = 1'b1;
					count_step = 1'b1;
					// done rises on this same edge for the last step
					if (last_step) begin
						next_state = stepper_pkg::idle;
					end
					else begin
						next_state = stepper_pkg::phase_low;
					end
				end
			end

			default: begin
				// unused encoding falls back to idle
				next_state = stepper_pkg::idle;
			end
		endcase
	end

	// trigger is ignored in both busy states
	// no branch above looks at it outside idle

endmodule : stepper_fsm

// ==== src/stepper_ctrl.sv ====
`timescale 1ns/10ps
`include "stepper_defs.svh"

module stepper_ctrl (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic trigger,
	input stepper_pkg::step_cmd_t cmd,
	output stepper_pkg::axis_status_t status
);

	stepper_pkg::step_cmd_t cmd_q;
	stepper_pkg::step_cmd_t cmd_sel;
	stepper_pkg::stepper_state_e state;

	logic [`STEP_COUNT_BITS-1:0] abs_steps;
	logic [`STEP_WIDTH_BITS-1:0] width_cnt;
	logic [`STEP_COUNT_BITS-1:0] step_cnt;

	logic phase_end;
	logic last_step;
	logic null_move;
	logic clear_width;
	logic count_step;

	// sequencer for this axis
	stepper_fsm fsm0 (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.trigger(trigger),
		.phase_end(phase_end),
		.last_step(last_step),
		.null_move(null_move),
		.state(state),
		.clear_width(clear_width),
		.count_step(count_step)
	);

	// command capture
	// follows the input on every idle tick, frozen while busy
	// cleared on reset so dir is defined right away
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_q <= '0;
		end
		else if (tick && (state == stepper_pkg::idle)) begin
			cmd_q <= cmd;
		end
	end

	// while idle the live command is the one being captured
	// on the trigger tick, so the null move test looks at it
	assign cmd_sel = (state == stepper_pkg::idle) ? cmd : cmd_q;
	assign null_move = (cmd_sel.width == '0) || (cmd_sel.steps == '0);

	// magnitude of the count
	// full width unsigned, so the most negative count still fits
	always_comb begin
		abs_steps = cmd_q.steps;
		if (cmd_q.steps[`STEP_COUNT_BITS-1]) begin
			// negate by two's complement
			abs_steps = ~cmd_q.steps + 1'b1;
		end
	end

	// width counter, ticks elapsed in the current phase
	// loads one on each phase start so a phase lasts width ticks
	always_ff @(posedge clk) begin
		if (reset) begin
			width_cnt <= `STEP_WIDTH_BITS'(1);
		end
		else if (clear_width) begin
			width_cnt <= `STEP_WIDTH_BITS'(1);
		end
		else if (tick && (state != stepper_pkg::idle)) begin
			width_cnt <= width_cnt + 1'b1;
		end
	end

	// the only phase length compare
	assign phase_end = (width_cnt == cmd_q.width);

	// step counter, number of the step in progress
	// parked at one while idle, so no start strobe is needed
	always_ff @(posedge clk) begin
		if (reset || (state == stepper_pkg::idle)) begin
			step_cnt <= `STEP_COUNT_BITS'(1);
		end
		else if (count_step) begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	// high during the final step of the move
	assign last_step = (step_cnt == abs_steps);

	// outputs straight from state
	// out only moves on the edge that follows a tick
	always_comb begin
		status.out = (state == stepper_pkg::phase_high);
		status.dir = cmd_q.steps[`STEP_COUNT_BITS-1];
		status.done = (state == stepper_pkg::idle);
	end

endmodule : stepper_ctrl

// ==== src/motion_top.sv ====
`timescale 1ns/10ps

module motion_top (
	input logic clk,
	input logic reset,
	input logic trigger,
	input stepper_pkg::step_cmd_t cmd_x,
	input stepper_pkg::step_cmd_t cmd_y,
	output stepper_pkg::axis_status_t status_x,
	output stepper_pkg::axis_status_t status_y
);

	// shared clock enable for both axes
	logic tick;

	tick_gen tick0 (
		.clk(clk),
		.reset(reset),
		.tick(tick)
	);

	// x axis
	stepper_ctrl axis_x (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.trigger(trigger),
		.cmd(cmd_x),
		.status(status_x)
	);

	// y axis
	// same trigger and tick, finishes on its own schedule
	stepper_ctrl axis_y (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.trigger(trigger),
		.cmd(cmd_y),
		.status(status_y)
	);

endmodule : motion_top

// ==== bench/motion_asserts.sv ====
`timescale 1ns/10ps

module motion_asserts (
	input logic clk,
	input logic reset,
	input logic tick,
	input stepper_pkg::axis_status_t status
);

	// a move only ends out of a high phase
	// done never rises straight from a low phase
	done_after_high: assert property (
		@(posedge clk) disable iff (reset)
		$rose(status.done) |-> $past(status.out)
	) else $error("done rose without a high phase in the cycle before");

	// dir frozen for the whole move
	// the first busy cycle is skipped, the capture edge may flip dir
	dir_stable_busy: assert property (
		@(posedge clk) disable iff (reset)
		(!status.done && !$past(status.done)) |-> $stable(status.dir)
	) else $error("dir changed while the axis was busy");

	// out only moves on the edge that follows a tick
	out_after_tick: assert property (
		@(posedge clk) disable iff (reset)
		!$stable(status.out) |-> $past(tick)
	) else $error("out changed without a tick in the cycle before");

endmodule : motion_asserts

// one checker per axis
bind stepper_ctrl motion_asserts asserts0 (
	.clk(clk),
	.reset(reset),
	.tick(tick),
	.status(status)
);

// ==== bench/motion_tb.sv ====
`timescale 1ns/10ps
`include "stepper_defs.svh"

module motion_tb;

	localparam int TIMEOUT_CYCLES = 5000;

	// expected outcome of one move on one axis
	typedef struct packed {
		int pulses;
		int width_clk;
		logic dir;
	} move_exp_t;

	logic clk;
	logic reset;
	logic trigger;
	stepper_pkg::step_cmd_t cmd_x;
	stepper_pkg::step_cmd_t cmd_y;
	stepper_pkg::axis_status_t status_x;
	stepper_pkg::axis_status_t status_y;
	stepper_pkg::step_cmd_t rand_x;
	stepper_pkg::step_cmd_t rand_y;

	// monitor results, index 0 is x and 1 is y
	int pulses [2];
	int busy [2];
	int run_len [2];
	int hi_min [2];
	int hi_max [2];
	int lo_min [2];
	int lo_max [2];
	logic prev_out [2];
	logic prev_done [2];

	logic [31:0] lcg_state;

	motion_top dut0 (
		.clk(clk),
		.reset(reset),
		.trigger(trigger),
		.cmd_x(cmd_x),
		.cmd_y(cmd_y),
		.status_x(status_x),
		.status_y(status_y)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// steps in -16..15 and width in 0..7, zero cases included
	function automatic stepper_pkg::step_cmd_t random_cmd();
		stepper_pkg::step_cmd_t c;
		lcg_state = lcg_next(lcg_state);
		c.steps = {{3{lcg_state[20]}}, lcg_state[20:16]};
		c.width = {5'b00000, lcg_state[26:24]};
		return c;
	endfunction

	function automatic stepper_pkg::step_cmd_t make_cmd(input int steps, input int width);
		stepper_pkg::step_cmd_t c;
		c.steps = steps[`STEP_COUNT_BITS-1:0];
		c.width = width[`STEP_WIDTH_BITS-1:0];
		return c;
	endfunction

	// reference model of one axis
	// |steps| pulses, each phase width ticks long, null move gives nothing
	function automatic move_exp_t expected_move(input stepper_pkg::step_cmd_t c);
		move_exp_t e;
		int s;
		s = $signed(c.steps);
		e.dir = (s < 0);
		e.width_clk = int'(c.width) * `STEP_TICK_DIV;
		if (c.width == 0 || s == 0) begin
			e.pulses = 0;
		end
		else begin
			e.pulses = (s < 0) ? -s : s;
		end
		return e;
	endfunction

	task automatic clear_stats(input int ax);
		pulses[ax] = 0;
		busy[ax] = 0;
		run_len[ax] = 0;
		hi_min[ax] = 1 << 30;
		hi_max[ax] = 0;
		lo_min[ax] = 1 << 30;
		lo_max[ax] = 0;
		prev_out[ax] = 1'b0;
		prev_done[ax] = 1'b1;
	endtask

	// fold a finished run into min and max
	task automatic note_run(input int ax, input logic high);
		if (high) begin
			hi_min[ax] = (run_len[ax] < hi_min[ax]) ? run_len[ax] : hi_min[ax];
			hi_max[ax] = (run_len[ax] > hi_max[ax]) ? run_len[ax] : hi_max[ax];
		end
		else begin
			lo_min[ax] = (run_len[ax] < lo_min[ax]) ? run_len[ax] : lo_min[ax];
			lo_max[ax] = (run_len[ax] > lo_max[ax]) ? run_len[ax] : lo_max[ax];
		end
	endtask

	// pulse monitor, one clk sample per call
	task automatic track_phase(input int ax, input stepper_pkg::axis_status_t st);
		// move start opens the first low run
		if (!st.done && prev_done[ax]) begin
			run_len[ax] = 0;
		end
		if (st.out && !prev_out[ax]) begin
			pulses[ax]++;
			note_run(ax, 1'b0);
			run_len[ax] = 0;
		end
		else if (!st.out && prev_out[ax]) begin
			note_run(ax, 1'b1);
			run_len[ax] = 0;
		end
		if (!st.done) begin
			run_len[ax]++;
			busy[ax]++;
		end
		prev_out[ax] = st.out;
		prev_done[ax] = st.done;
	endtask

	// outputs sampled mid cycle, away from the drive edge
	always @(negedge clk) begin
		if (!reset) begin
			track_phase(0, status_x);
			track_phase(1, status_y);
		end
	end

	task automatic check_status(input string name, input stepper_pkg::axis_status_t expv,
			input stepper_pkg::axis_status_t actv);
		if (actv !== expv) begin
			$display("FAILED %s expected %b actual %b", name, expv, actv);
			$display("TEST FAILED");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_count(input string name, input int expv, input int actv);
		if (actv != expv) begin
			$display("FAILED %s expected %0d actual %0d", name, expv, actv);
			$display("TEST FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_width(input string name, input int expv, input int actv);
		if (actv != expv) begin
			$display("FAILED %s expected %0d actual %0d", name, expv, actv);
			$display("TEST FAILED");
			$fatal(1, "width mismatch");
		end
	endtask

	task automatic check_axis(input string name, input int ax, input stepper_pkg::step_cmd_t c,
			input stepper_pkg::axis_status_t st);
		move_exp_t e;
		stepper_pkg::axis_status_t st_exp;
		e = expected_move(c);
		st_exp.out = 1'b0;
		st_exp.dir = e.dir;
		st_exp.done = 1'b1;
		check_count({name, " pulses"}, e.pulses, pulses[ax]);
		// busy time is both phases of every step
		check_count({name, " busy cycles"}, 2 * e.pulses * e.width_clk, busy[ax]);
		if (e.pulses > 0) begin
			check_width({name, " high min"}, e.width_clk, hi_min[ax]);
			check_width({name, " high max"}, e.width_clk, hi_max[ax]);
			check_width({name, " low min"}, e.width_clk, lo_min[ax]);
			check_width({name, " low max"}, e.width_clk, lo_max[ax]);
		end
		check_status({name, " status"}, st_exp, st);
	endtask

	task automatic wait_done(input string name);
		int cycles;
		cycles = 0;
		while (!(status_x.done && status_y.done)) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("%s: done never returned high within %0d cycles", name, cycles);
				$display("TEST FAILED");
				$fatal(1, "timeout waiting for done");
			end
		end
	endtask

	// trigger held one tick period, so exactly one tick samples it
	task automatic start_move(input stepper_pkg::step_cmd_t cx, input stepper_pkg::step_cmd_t cy);
		@(posedge clk);
		#1;
		cmd_x = cx;
		cmd_y = cy;
		clear_stats(0);
		clear_stats(1);
		trigger = 1'b1;
		repeat (`STEP_TICK_DIV) @(posedge clk);
		#1;
		trigger = 1'b0;
	endtask

	task automatic finish_move(input string name, input stepper_pkg::step_cmd_t cx,
			input stepper_pkg::step_cmd_t cy);
		wait_done(name);
		// let the monitor close the last high run
		@(negedge clk);
		#1;
		check_axis({name, " x"}, 0, cx, status_x);
		check_axis({name, " y"}, 1, cy, status_y);
	endtask

	task automatic run_move(input string name, input stepper_pkg::step_cmd_t cx,
			input stepper_pkg::step_cmd_t cy);
		start_move(cx, cy);
		finish_move(name, cx, cy);
	endtask

	initial begin
		reset = 1'b1;
		trigger = 1'b0;
		cmd_x = '0;
		cmd_y = '0;
		lcg_state = 32'd12;
		clear_stats(0);
		clear_stats(1);
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// quiet after reset
		repeat (50) @(posedge clk);
		#1;
		check_axis("after reset x", 0, '0, status_x);
		check_axis("after reset y", 1, '0, status_y);

		// positive move on x alone
		run_move("positive x", make_cmd(3, 2), make_cmd(0, 0));

		// negative count on y while x runs its own move
		run_move("negative y", make_cmd(2, 3), make_cmd(-5, 1));

		// zero width on x, zero steps on y
		run_move("null move", make_cmd(3, 0), make_cmd(0, 4));

		// retrigger and new command while x is busy
		start_move(make_cmd(4, 2), make_cmd(0, 0));
		repeat (10) @(posedge clk);
		#1;
		trigger = 1'b1;
		cmd_x = make_cmd(-7, 5);
		repeat (8) @(posedge clk);
		#1;
		trigger = 1'b0;
		cmd_x = make_cmd(4, 2);
		finish_move("mid move", make_cmd(4, 2), make_cmd(0, 0));

		// random commands on both axes
		for (int i = 0; i < 20; i++) begin
			rand_x = random_cmd();
			rand_y = random_cmd();
			run_move($sformatf("random %0d", i), rand_x, rand_y);
		end

		$display("TEST OK");
		$finish;
	end

endmodule : motion_tb

// ==== motion.f ====
+incdir+src
src/stepper_pkg.sv
src/tick_gen.sv
src/stepper_fsm.sv
src/stepper_ctrl.sv
src/motion_top.sv
bench/motion_asserts.sv
bench/motion_tb.sv

// ==== Makefile ====
TOP = motion_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f motion.f -o motion_sim

run: compile
	./obj_dir/motion_sim > sim.log 2>&1; cat sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
